/* src/sd_proto_pkg.sv */
package sd_proto_pkg;

  // response type select, encoded as in the host command register
  typedef enum logic [1:0] {
    RSP_NONE       = 2'b00,  // no response expected
    RSP_LONG       = 2'b01,  // 136 bit frame, R2
    RSP_SHORT      = 2'b10,  // 48 bit frame
    RSP_SHORT_BUSY = 2'b11   // 48 bit frame, busy on dat0 afterwards
  } rsp_type_e;

  // frame lengths on the cmd line, start and end bit included
  localparam int unsigned CMD_FRAME_LEN = 48;
  localparam int unsigned SHORT_RSP_LEN = 48;
  localparam int unsigned LONG_RSP_LEN  = 136;

  // x^7 + x^3 + 1, the x^7 term is implicit
  localparam logic [6:0] CRC7_POLY = 7'h09;

  // field widths
  localparam int unsigned CMD_IDX_W = 6;    // command index
  localparam int unsigned CMD_ARG_W = 32;   // command argument
  localparam int unsigned RSP_W     = 120;  // response payload

endpackage

/* src/sd_host_pkg.sv */
package sd_host_pkg;

  // command sequencer states
  typedef enum logic [2:0] {
    SEQ_IDLE,        // ready for a host request
    SEQ_WRITE,       // command frame on the line
    SEQ_SWITCH,      // bus turnaround before listening
    SEQ_READ,        // waiting for or receiving the response
    SEQ_READ_BUSY,   // same, then wait for dat0 to leave busy
    SEQ_TURNAROUND   // N_RC gap before the next command
  } cmd_seq_state_e;

  // error flags reported with each finished command
  typedef struct packed {
    logic timeout;   // no start bit in time
    logic crc;       // crc7 mismatch
    logic index;     // echoed index differs
    logic end_bit;   // end bit was low
  } cmd_err_t;

endpackage

/* src/cmd_tx_if.sv */
interface cmd_tx_if import sd_proto_pkg::*; ();

  logic                 valid;     // request pending
  logic                 ready;     // writer idle
  logic                 done;      // pulse after the end bit
  logic [CMD_IDX_W-1:0] index;
  logic [CMD_ARG_W-1:0] argument;

  modport seq (
    output valid, index, argument,
    input  ready, done
  );

  modport writer (
    input  valid, index, argument,
    output ready, done
  );

endinterface

/* src/rsp_rx_if.sv */
interface rsp_rx_if import sd_proto_pkg::*; ();

  logic             listen;       // look for a start bit
  logic             long_rsp;     // expect 136 bits instead of 48
  logic             receiving;    // frame in progress
  logic             valid;        // one cycle, results below are stable
  logic [RSP_W-1:0] payload;
  logic             crc_ok;
  logic             end_bit_err;

  modport seq (
    output listen, long_rsp,
    input  receiving, valid, payload, crc_ok, end_bit_err
  );

  modport reader (
    input  listen, long_rsp,
    output receiving, valid, payload, crc_ok, end_bit_err
  );

endinterface

/* src/crc7.sv */
module crc7 import sd_proto_pkg::*; (
  input  logic       sd_clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,  // start over from zero, may come with shift_i
  input  logic       shift_i,
  input  logic       bit_i,
  output logic [6:0] crc_o
);

  logic [6:0] crc_q, crc_d, base;
  logic       feedback;

  always_comb begin
    base     = clear_i ? 7'd0 : crc_q;
    feedback = bit_i ^ base[6];
    crc_d    = base;
    if (shift_i) begin
      crc_d = {base[5:0], 1'b0} ^ (feedback ? CRC7_POLY : 7'd0);
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (!rst_ni) begin
      crc_q <= 7'd0;
    end else begin
      crc_q <= crc_d;
    end
  end

  assign crc_o = crc_q;

endmodule

/* src/cmd_write.sv */
module cmd_write import sd_proto_pkg::*; (
  input  logic     sd_clk_i,
  input  logic     rst_ni,
  cmd_tx_if.writer tx,
  output logic     cmd_o,
  output logic     cmd_en_o
);

  localparam int unsigned TAIL_LEN = 8;                        // crc7 and end bit
  localparam int unsigned BODY_LEN = CMD_FRAME_LEN - TAIL_LEN;  // bits covered by crc7
  localparam int unsigned CNT_W    = $clog2(CMD_FRAME_LEN);

  logic                busy_q, done_q, cmd_q, cmd_en_q;
  logic [CNT_W-1:0]    bit_q;       // frame position of the bit on the line
  logic [BODY_LEN-2:0] frame_q;     // body after the start bit, msb next
  logic                accept, crc_shift, crc_bit;
  logic [6:0]          crc;
  logic [2:0]          crc_sel;

  assign accept    = tx.valid && tx.ready;
  assign crc_shift = accept || (busy_q && (bit_q > CNT_W'(TAIL_LEN)));
  assign crc_bit   = accept ? 1'b0 : frame_q[BODY_LEN-2];  // start bit first
  assign crc_sel   = 3'(bit_q - CNT_W'(2));                 // bit 7 of the frame is crc[6]

  crc7 i_crc7 (
    .sd_clk_i (sd_clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (accept),
    .shift_i  (crc_shift),
    .bit_i    (crc_bit),
    .crc_o    (crc)
  );

  always_ff @(posedge sd_clk_i) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      cmd_q    <= 1'b1;  // line idles high
      cmd_en_q <= 1'b0;
      bit_q    <= '0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy_q   <= 1'b1;
        cmd_en_q <= 1'b1;
        cmd_q    <= 1'b0;  // start bit
        bit_q    <= CNT_W'(CMD_FRAME_LEN - 1);
      end else if (busy_q) begin
        bit_q <= bit_q - CNT_W'(1);
        if (bit_q == '0) begin  // end bit was out this cycle
          busy_q   <= 1'b0;
          cmd_en_q <= 1'b0;
          cmd_q    <= 1'b1;
          done_q   <= 1'b1;
        end else if (bit_q > CNT_W'(TAIL_LEN)) begin
          cmd_q <= frame_q[BODY_LEN-2];
        end else if (bit_q > CNT_W'(1)) begin
          cmd_q <= crc[crc_sel];
        end else begin
          cmd_q <= 1'b1;  // end bit
        end
      end
    end
  end

  // direction bit, index and argument
  always_ff @(posedge sd_clk_i) begin
    if (accept) begin
      frame_q <= {1'b1, tx.index, tx.argument};
    end else if (busy_q) begin
      frame_q <= {frame_q[BODY_LEN-3:0], 1'b0};
    end
  end

  assign tx.ready = !busy_q;
  assign tx.done  = done_q;
  assign cmd_o    = cmd_q;
  assign cmd_en_o = cmd_en_q;

endmodule

/* src/rsp_read.sv */
module rsp_read import sd_proto_pkg::*; (
  input  logic     sd_clk_i,
  input  logic     rst_ni,
  rsp_rx_if.reader rx,
  input  logic     cmd_i
);

  localparam int unsigned SR_W    = RSP_W + 7;           // payload plus the crc field
  localparam int unsigned CNT_W   = $clog2(LONG_RSP_LEN);
  localparam int unsigned CRC_END = SHORT_RSP_LEN - 8;   // crc covers bits 0 to 39

  logic             receiving_q, valid_q, crc_ok_q, end_err_q;
  logic [CNT_W-1:0] cnt_q;      // index of the bit sampled this cycle
  logic [CNT_W-1:0] last_idx;
  logic [SR_W-1:0]  sr_q;
  logic             start, end_bit, crc_shift;
  logic [6:0]       crc;

  assign last_idx  = rx.long_rsp ? CNT_W'(LONG_RSP_LEN - 1) : CNT_W'(SHORT_RSP_LEN - 1);
  assign start     = rx.listen && !receiving_q && !valid_q && !cmd_i;
  assign end_bit   = receiving_q && (cnt_q == last_idx);
  assign crc_shift = start || (receiving_q && !rx.long_rsp && (cnt_q < CNT_W'(CRC_END)));

  crc7 i_crc7 (
    .sd_clk_i (sd_clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (start),
    .shift_i  (crc_shift),
    .bit_i    (cmd_i),
    .crc_o    (crc)
  );

  always_ff @(posedge sd_clk_i) begin
    if (!rst_ni) begin
      receiving_q <= 1'b0;
      valid_q     <= 1'b0;
      crc_ok_q    <= 1'b0;
      end_err_q   <= 1'b0;
      cnt_q       <= '0;
    end else begin
      valid_q <= 1'b0;
      if (start) begin
        receiving_q <= 1'b1;
        cnt_q       <= CNT_W'(1);
      end else if (end_bit) begin
        receiving_q <= 1'b0;
        valid_q     <= 1'b1;
        crc_ok_q    <= (crc == sr_q[6:0]);  // crc field is the last shifted in
        end_err_q   <= !cmd_i;
      end else if (receiving_q) begin
        cnt_q <= cnt_q + CNT_W'(1);
      end
    end
  end

  // every bit except the end bit, so the payload ends right before the crc field
  always_ff @(posedge sd_clk_i) begin
    if (start || (receiving_q && !end_bit)) begin
      sr_q <= {sr_q[SR_W-2:0], cmd_i};
    end
  end

  assign rx.receiving   = receiving_q;
  assign rx.valid       = valid_q;
  assign rx.payload     = sr_q[SR_W-1:7];
  assign rx.crc_ok      = crc_ok_q;
  assign rx.end_bit_err = end_err_q;

endmodule

/* src/cmd_wrap.sv */
module cmd_wrap import sd_proto_pkg::*, sd_host_pkg::*; #(
  parameter int unsigned TIMEOUT_CYCLES = 64,
  parameter int unsigned NRC_CYCLES     = 8
) (
  input  logic                 sd_clk_i,
  input  logic                 rst_ni,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  input  logic [CMD_IDX_W-1:0] cmd_index_i,
  input  logic [CMD_ARG_W-1:0] cmd_arg_i,
  input  rsp_type_e            rsp_type_i,
  input  logic                 crc_check_i,
  input  logic                 index_check_i,
  input  logic                 busy_dat0_i,   // low while the card is busy
  cmd_tx_if.seq                tx,
  rsp_rx_if.seq                rx,
  output logic                 done_o,
  output logic [RSP_W-1:0]     rsp_o,
  output cmd_err_t             err_o
);

  localparam int unsigned CNT_MAX = (TIMEOUT_CYCLES > NRC_CYCLES) ? TIMEOUT_CYCLES : NRC_CYCLES;
  localparam int unsigned CNT_W   = $clog2(CNT_MAX + 1);

  cmd_seq_state_e       state_q, state_d;
  logic [CNT_W-1:0]     cnt_q, cnt_d;      // switch, timeout and N_RC counter
  logic [CMD_IDX_W-1:0] idx_q;
  logic [CMD_ARG_W-1:0] arg_q;
  rsp_type_e            type_q;
  logic                 crc_chk_q, idx_chk_q;
  logic                 tx_pending_q, rsp_got_q, done_q;
  cmd_err_t             err_rx, err_stage_q, err_done, err_q;
  logic [RSP_W-1:0]     rsp_stage_q, rsp_q;
  logic                 accept, long_sel, reading, waiting, timed_out, finish;

  assign accept    = cmd_valid_i && cmd_ready_o;
  assign long_sel  = (type_q == RSP_LONG);
  assign reading   = (state_q == SEQ_READ) || (state_q == SEQ_READ_BUSY);
  assign waiting   = reading && !rsp_got_q && !rx.receiving && !rx.valid;
  assign timed_out = waiting && (cnt_q == CNT_W'(TIMEOUT_CYCLES - 1));
  assign finish    = (state_d == SEQ_TURNAROUND) && (state_q != SEQ_TURNAROUND);

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      SEQ_IDLE:  if (accept) state_d = SEQ_WRITE;
      SEQ_WRITE: begin
        if (tx.done) state_d = (type_q == RSP_NONE) ? SEQ_TURNAROUND : SEQ_SWITCH;
      end
      SEQ_SWITCH: begin
        cnt_d = cnt_q + CNT_W'(1);
        if (cnt_q == CNT_W'(1)) begin
          state_d = (type_q == RSP_SHORT_BUSY) ? SEQ_READ_BUSY : SEQ_READ;
        end
      end
      SEQ_READ, SEQ_READ_BUSY: begin
        if (waiting) cnt_d = cnt_q + CNT_W'(1);
        if (timed_out) begin
          state_d = SEQ_TURNAROUND;
        end else if (rsp_got_q && (state_q == SEQ_READ || busy_dat0_i)) begin
          state_d = SEQ_TURNAROUND;  // r1b also waits for dat0 to go high
        end
      end
      SEQ_TURNAROUND: begin
        cnt_d = cnt_q + CNT_W'(1);
        if (cnt_q == CNT_W'(NRC_CYCLES - 1)) state_d = SEQ_IDLE;
      end
      default: state_d = SEQ_IDLE;
    endcase
    if (state_d != state_q) cnt_d = '0;  // every state starts counting from zero
  end

  // long responses carry their crc inside the payload and no index
  always_comb begin
    err_rx         = '0;
    err_rx.crc     = crc_chk_q && !long_sel && !rx.crc_ok;
    err_rx.index   = idx_chk_q && !long_sel && (rx.payload[CMD_ARG_W +: CMD_IDX_W] != idx_q);
    err_rx.end_bit = rx.end_bit_err;
  end

  always_comb begin
    err_done = '0;
    if (timed_out) begin
      err_done.timeout = 1'b1;
    end else if (rsp_got_q) begin
      err_done = err_stage_q;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (!rst_ni) begin
      state_q      <= SEQ_IDLE;
      cnt_q        <= '0;
      tx_pending_q <= 1'b0;
      rsp_got_q    <= 1'b0;
      done_q       <= 1'b0;
      err_q        <= '0;
      rsp_q        <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      done_q  <= finish;
      if (accept) begin
        tx_pending_q <= 1'b1;
      end else if (tx.valid && tx.ready) begin
        tx_pending_q <= 1'b0;
      end
      if (rx.valid) begin
        rsp_got_q <= 1'b1;
      end else if (finish) begin
        rsp_got_q <= 1'b0;
      end
      if (finish) begin
        err_q <= err_done;
        if (rsp_got_q && !timed_out) rsp_q <= rsp_stage_q;  // no response keeps the old one
      end
    end
  end

  // request fields and staged results
  always_ff @(posedge sd_clk_i) begin
    if (accept) begin
      idx_q     <= cmd_index_i;
      arg_q     <= cmd_arg_i;
      type_q    <= rsp_type_i;
      crc_chk_q <= crc_check_i;
      idx_chk_q <= index_check_i;
    end
    if (rx.valid) begin
      err_stage_q <= err_rx;
      rsp_stage_q <= long_sel ? rx.payload : RSP_W'(rx.payload[CMD_ARG_W-1:0]);
    end
  end

  assign cmd_ready_o = (state_q == SEQ_IDLE);
  assign tx.valid    = tx_pending_q;
  assign tx.index    = idx_q;
  assign tx.argument = arg_q;
  assign rx.listen   = reading && !rsp_got_q;
  assign rx.long_rsp = long_sel;
  assign done_o      = done_q;
  assign rsp_o       = rsp_q;
  assign err_o       = err_q;

endmodule

/* src/sd_cmd_top.sv */
module sd_cmd_top import sd_proto_pkg::*, sd_host_pkg::*; #(
  parameter int unsigned TIMEOUT_CYCLES = 64,
  parameter int unsigned NRC_CYCLES     = 8
) (
  input  logic                 sd_clk_i,
  input  logic                 rst_ni,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  input  logic [CMD_IDX_W-1:0] cmd_index_i,
  input  logic [CMD_ARG_W-1:0] cmd_arg_i,
  input  rsp_type_e            rsp_type_i,
  input  logic                 crc_check_i,
  input  logic                 index_check_i,
  input  logic                 sd_cmd_i,
  output logic                 sd_cmd_o,
  output logic                 sd_cmd_en_o,
  input  logic                 busy_dat0_i,
  output logic                 done_o,
  output logic [RSP_W-1:0]     rsp_o,
  output logic                 err_timeout_o,
  output logic                 err_crc_o,
  output logic                 err_index_o,
  output logic                 err_end_bit_o
);

  cmd_err_t err;

  cmd_tx_if i_tx_if ();
  rsp_rx_if i_rx_if ();

  cmd_wrap #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .NRC_CYCLES     (NRC_CYCLES)
  ) i_cmd_wrap (
    .sd_clk_i      (sd_clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_index_i   (cmd_index_i),
    .cmd_arg_i     (cmd_arg_i),
    .rsp_type_i    (rsp_type_i),
    .crc_check_i   (crc_check_i),
    .index_check_i (index_check_i),
    .busy_dat0_i   (busy_dat0_i),
    .tx            (i_tx_if.seq),
    .rx            (i_rx_if.seq),
    .done_o        (done_o),
    .rsp_o         (rsp_o),
    .err_o         (err)
  );

  cmd_write i_cmd_write (
    .sd_clk_i (sd_clk_i),
    .rst_ni   (rst_ni),
    .tx       (i_tx_if.writer),
    .cmd_o    (sd_cmd_o),
    .cmd_en_o (sd_cmd_en_o)
  );

  rsp_read i_rsp_read (
    .sd_clk_i (sd_clk_i),
    .rst_ni   (rst_ni),
    .rx       (i_rx_if.reader),
    .cmd_i    (sd_cmd_i)
  );

  assign err_timeout_o = err.timeout;
  assign err_crc_o     = err.crc;
  assign err_index_o   = err.index;
  assign err_end_bit_o = err.end_bit;

endmodule

/* sim/sd_card_model.sv */
module sd_card_model (
  input  logic         clk_i,
  input  logic         cmd_i,          // host cmd line
  input  logic         cmd_en_i,       // host drives the line
  input  logic         respond_i,      // 0 keeps the card silent
  input  int unsigned  gap_i,          // cycles from end bit to response start
  input  logic [135:0] rsp_frame_i,    // right aligned, msb goes first
  input  int unsigned  rsp_len_i,
  input  int unsigned  busy_cycles_i,  // dat0 low time after the response
  output logic         cmd_o,
  output logic         busy_o,
  output logic [47:0]  frame_o,        // last command frame seen
  output int unsigned  frame_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // the host drives on the rising edge, so the falling edge sees a stable bit
  initial begin
    cmd_o       = 1'b1;
    busy_o      = 1'b1;
    frame_o     = '0;
    frame_cnt_o = 0;
    forever begin
      @(negedge clk_i);
      if (cmd_en_i) begin
        for (int i = 47; i >= 0; i--) begin
          frame_o[i] = cmd_i;
          if (i > 0) @(negedge clk_i);
        end
        frame_cnt_o = frame_cnt_o + 1;
        if (respond_i) begin
          repeat (gap_i) @(negedge clk_i);
          for (int i = int'(rsp_len_i) - 1; i >= 0; i--) begin
            cmd_o = rsp_frame_i[i];
            @(negedge clk_i);
          end
          cmd_o = 1'b1;
          if (busy_cycles_i > 0) begin
            busy_o = 1'b0;  // r1b style busy right after the end bit
            repeat (busy_cycles_i) @(negedge clk_i);
            busy_o = 1'b1;
          end
        end
      end
    end
  end

endmodule

/* sim/tb_sd_cmd.sv */
module tb_sd_cmd import sd_proto_pkg::*; ;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_PERIOD     = 100;
  localparam int unsigned TIMEOUT_CYCLES = 64;
  localparam int unsigned NRC_CYCLES     = 8;
  localparam int unsigned NUM_TESTS      = 6;
  localparam int unsigned DONE_LIMIT     = 400;  // cycles allowed for one command

  typedef logic [135:0] wide_t;

  logic         clk, rst_n, cmd_valid, cmd_ready, crc_chk, idx_chk;
  logic [5:0]   cmd_idx;
  logic [31:0]  cmd_arg;
  rsp_type_e    rsp_type;
  logic         line_in, line_out, line_en, busy_dat0, done;
  logic [119:0] rsp;
  logic         err_timeout, err_crc, err_index, err_end_bit;
  logic [3:0]   err_bits;
  logic         card_respond;
  int unsigned  card_gap, card_len, card_busy, frame_cnt;
  wide_t        card_frame;
  logic [47:0]  card_seen;
  logic [31:0]  rng_q = 32'd35769;
  int unsigned  busy_low, error_cnt, sent_cnt;
  logic         busy_last;

  assign err_bits = {err_timeout, err_crc, err_index, err_end_bit};

  sd_cmd_top #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .NRC_CYCLES     (NRC_CYCLES)
  ) i_dut (
    .sd_clk_i      (clk),
    .rst_ni        (rst_n),
    .cmd_valid_i   (cmd_valid),
    .cmd_ready_o   (cmd_ready),
    .cmd_index_i   (cmd_idx),
    .cmd_arg_i     (cmd_arg),
    .rsp_type_i    (rsp_type),
    .crc_check_i   (crc_chk),
    .index_check_i (idx_chk),
    .sd_cmd_i      (line_in),
    .sd_cmd_o      (line_out),
    .sd_cmd_en_o   (line_en),
    .busy_dat0_i   (busy_dat0),
    .done_o        (done),
    .rsp_o         (rsp),
    .err_timeout_o (err_timeout),
    .err_crc_o     (err_crc),
    .err_index_o   (err_index),
    .err_end_bit_o (err_end_bit)
  );

  sd_card_model i_card (
    .clk_i         (clk),
    .cmd_i         (line_out),
    .cmd_en_i      (line_en),
    .respond_i     (card_respond),
    .gap_i         (card_gap),
    .rsp_frame_i   (card_frame),
    .rsp_len_i     (card_len),
    .busy_cycles_i (card_busy),
    .cmd_o         (line_in),
    .busy_o        (busy_dat0),
    .frame_o       (card_seen),
    .frame_cnt_o   (frame_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_TESTS * DONE_LIMIT * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in time");
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog");
  end

  function automatic logic [31:0] next_rand();
    rng_q ^= rng_q << 13;
    rng_q ^= rng_q >> 17;
    rng_q ^= rng_q << 5;
    return rng_q;
  endfunction

  // x^7 + x^3 + 1 over the bits msb first
  function automatic logic [6:0] crc7_calc(input logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = bits[i] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  function automatic wide_t short_frame(input logic [5:0] idx, input logic [31:0] status,
                                        input logic bad_crc, input logic bad_idx,
                                        input logic bad_end);
    logic [39:0] body;
    body = {2'b00, idx ^ {5'd0, bad_idx}, status};  // crc stays valid for a wrong index
    return {88'd0, body, crc7_calc(body) ^ {6'd0, bad_crc}, !bad_end};
  endfunction

  task automatic check_value(input string what, input wide_t got, input wide_t exp);
    if (got !== exp) begin
      error_cnt++;
      $display("FAIL %0d ns: %s got %h expected %h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic abort_run(input string msg);
    error_cnt++;
    $display("%s at %0d ns", msg, $time);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic set_card(input logic respond, input int unsigned gap, input wide_t frame,
                          input int unsigned len, input int unsigned busy);
    card_respond = respond;
    card_gap     = gap;  // 4 or more reaches the listen window
    card_frame   = frame;
    card_len     = len;
    card_busy    = busy;
  endtask

  // issue one request and wait for done with ready kept low
  task automatic run_cmd(input logic [5:0] idx, input logic [31:0] arg, input rsp_type_e typ,
                         input logic crc_c, input logic idx_c);
    int unsigned cycles;
    while (!cmd_ready) @(negedge clk);
    cmd_valid = 1'b1;
    cmd_idx   = idx;
    cmd_arg   = arg;
    rsp_type  = typ;
    crc_chk   = crc_c;
    idx_chk   = idx_c;
    @(negedge clk);
    cmd_valid = 1'b0;
    sent_cnt++;
    cycles    = 0;
    busy_low  = 0;
    do begin
      @(posedge clk);
      busy_last = busy_dat0;
      if (!busy_dat0) busy_low++;
      @(negedge clk);
      cycles++;
      if (!done && cmd_ready) abort_run("controller became ready before done");
      if (cycles > DONE_LIMIT) abort_run("done never came for the command");
    end while (!done);
    check_value("frames on the line", wide_t'(frame_cnt), wide_t'(sent_cnt));
  endtask

  task automatic check_frame(input logic [5:0] idx, input logic [31:0] arg);
    logic [39:0] body;
    body = {2'b01, idx, arg};
    check_value("cmd frame", wide_t'(card_seen), wide_t'({body, crc7_calc(body), 1'b1}));
  endtask

  task automatic test_short();
    logic [5:0]  idx;
    logic [31:0] arg, status;
    idx    = 6'(next_rand());
    arg    = next_rand();
    status = next_rand();
    set_card(1'b1, 5, short_frame(idx, status, 1'b0, 1'b0, 1'b0), 48, 0);
    run_cmd(idx, arg, RSP_SHORT, 1'b1, 1'b1);
    check_frame(idx, arg);
    check_value("short rsp", wide_t'(rsp), wide_t'(status));
    check_value("short errors", wide_t'(err_bits), wide_t'(4'b0000));
  endtask

  task automatic test_long();
    logic [119:0] payload;
    logic [31:0]  arg;
    arg     = next_rand();
    payload = 120'({next_rand(), next_rand(), next_rand(), next_rand()});
    set_card(1'b1, 7, {2'b00, 6'h3f, payload, 7'(next_rand()), 1'b1}, 136, 0);
    run_cmd(6'd2, arg, RSP_LONG, 1'b1, 1'b1);
    check_frame(6'd2, arg);
    check_value("long rsp", wide_t'(rsp), wide_t'(payload));
    check_value("long errors", wide_t'(err_bits), wide_t'(4'b0000));
  endtask

  task automatic test_none();
    logic [119:0] prev;
    int unsigned  gap;
    prev = rsp;
    set_card(1'b0, 5, '0, 48, 0);
    run_cmd(6'd0, 32'd0, RSP_NONE, 1'b0, 1'b0);
    check_frame(6'd0, 32'd0);
    check_value("rsp kept", wide_t'(rsp), wide_t'(prev));
    check_value("none errors", wide_t'(err_bits), wide_t'(4'b0000));
    gap = 0;
    while (!cmd_ready) begin
      gap++;
      @(negedge clk);
    end
    check_value("ready gap at least N_RC", wide_t'(gap >= NRC_CYCLES), wide_t'(1));
  endtask

  task automatic error_case(input logic bad_crc, input logic bad_idx, input logic bad_end,
                            input logic crc_c, input logic idx_c, input logic [3:0] exp);
    logic [5:0]  idx;
    logic [31:0] status;
    idx    = 6'(next_rand());
    status = next_rand();
    set_card(1'b1, 4 + (next_rand() % 7), short_frame(idx, status, bad_crc, bad_idx, bad_end),
             48, 0);
    run_cmd(idx, next_rand(), RSP_SHORT, crc_c, idx_c);
    check_value("error flags", wide_t'(err_bits), wide_t'(exp));
  endtask

  task automatic test_errors();
    error_case(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000);  // crc not checked
    error_case(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 4'b0100);
    error_case(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4'b0000);
    error_case(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 4'b0010);
    error_case(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 4'b0001);
  endtask

  task automatic test_timeout();
    set_card(1'b0, 5, '0, 48, 0);
    run_cmd(6'd13, next_rand(), RSP_SHORT, 1'b1, 1'b1);
    check_value("timeout flags", wide_t'(err_bits), wide_t'(4'b1000));
    error_case(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 4'b0000);  // next command still goes through
  endtask

  task automatic test_busy();
    logic [31:0] status;
    status = next_rand();
    set_card(1'b1, 6, short_frame(6'd7, status, 1'b0, 1'b0, 1'b0), 48, 20);
    run_cmd(6'd7, next_rand(), RSP_SHORT_BUSY, 1'b1, 1'b1);
    check_value("busy cycles seen", wide_t'(busy_low), wide_t'(20));
    check_value("dat0 released at done", wide_t'(busy_last), wide_t'(1));
    check_value("busy rsp", wide_t'(rsp), wide_t'(status));
    check_value("busy errors", wide_t'(err_bits), wide_t'(4'b0000));
  endtask

  initial begin
    error_cnt = 0;
    sent_cnt  = 0;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_idx   = '0;
    cmd_arg   = '0;
    rsp_type  = RSP_NONE;
    crc_chk   = 1'b0;
    idx_chk   = 1'b0;
    set_card(1'b0, 5, '0, 48, 0);
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_value("ready after reset", wide_t'(cmd_ready), wide_t'(1));
    check_value("line after reset", wide_t'({line_out, line_en, done}), wide_t'(3'b100));
    check_value("errors after reset", wide_t'(err_bits), wide_t'(4'b0000));
    test_short();
    test_long();
    test_none();
    test_errors();
    test_timeout();
    test_busy();
    if (error_cnt == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1, "errors found");
    end
  end

endmodule

/* project.f */
src/sd_proto_pkg.sv
src/sd_host_pkg.sv
src/cmd_tx_if.sv
src/rsp_rx_if.sv
src/crc7.sv
src/cmd_write.sv
src/rsp_read.sv
src/cmd_wrap.sv
src/sd_cmd_top.sv
sim/sd_card_model.sv
sim/tb_sd_cmd.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary -f project.f --top-module tb_sd_cmd -o sim_tb &&
./obj_dir/sim_tb | grep "ALL TESTS PASSED" || { echo "simulation failed"; exit 1; }
